// ==== hw/game_pkg.sv ====
package game_pkg;

    // Pages of the game, one of them current at any time
    typedef enum logic [1:0] {
        PAGE_MENU    = 2'd0,
        PAGE_HISTORY = 2'd1,
        PAGE_PLAY    = 2'd2
    } page_t;

    // One finished play as it is kept in the record memory
    typedef struct packed {
        logic [3:0] user_id;
        logic [1:0] chart_id;
        logic [3:0] score;
    } record_t;

    localparam int NUM_CHARTS = 4;
    localparam int CHART_LEN  = 8;
    localparam int NOTE_TICKS = 4;

    // Navigation button positions in btn_arr
    localparam int BTN_UP   = 0;
    localparam int BTN_DOWN = 1;
    localparam int BTN_OK   = 2;
    localparam int BTN_BACK = 3;

    // Note index 0..6 per step; neighbours differ so every step changes the cue
    localparam logic [2:0] CHART_TABLE [NUM_CHARTS][CHART_LEN] = '{
        '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd0},
        '{3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd6},
        '{3'd0, 3'd2, 3'd4, 3'd6, 3'd1, 3'd3, 3'd5, 3'd0},
        '{3'd3, 3'd1, 3'd4, 3'd0, 3'd5, 3'd2, 3'd6, 3'd3}
    };

endpackage

// ==== hw/prog_tick_gen.sv ====
module prog_tick_gen #(
    parameter int FREQ_DIV = 1000
) (
    input  logic clk,
    input  logic sys_rst,
    output logic tick
);

    localparam int CW = (FREQ_DIV > 1) ? $clog2(FREQ_DIV) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            cnt <= '0;
        end else if (cnt == CW'(FREQ_DIV - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One program tick per counter wrap
    assign tick = (cnt == CW'(FREQ_DIV - 1));

endmodule

// ==== hw/key_events.sv ====
module key_events (
    input  logic       clk,
    input  logic       sys_rst,
    input  logic       tick,
    input  logic [3:0] btn_arr,
    input  logic [6:0] btn_notes,
    output logic [3:0] nav_press,
    output logic [6:0] note_press
);

    logic [10:0] btn_all;
    logic [10:0] sync1;
    logic [10:0] sync2;
    logic [10:0] lvl;
    logic [10:0] press_all;

    // Notes in the upper bits, navigation in the lower ones
    assign btn_all = {btn_notes, btn_arr};

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            sync1 <= '0;
            sync2 <= '0;
            lvl   <= '0;
        end else begin
            sync1 <= btn_all;
            sync2 <= sync1;
            // Level as seen on the previous tick
            if (tick) begin
                lvl <= sync2;
            end
        end
    end

    // Rising edge between two tick samples, valid in the tick cycle only
    assign press_all  = {11{tick}} & sync2 & ~lvl;
    assign nav_press  = press_all[3:0];
    assign note_press = press_all[10:4];

endmodule

// ==== hw/record_store.sv ====
module record_store import game_pkg::*; #(
    parameter int NUM_RECORDS = 8
) (
    input  logic                               clk,
    input  logic                               sys_rst,
    input  logic                               wr,
    input  record_t                            wr_data,
    input  logic                               rd,
    input  logic [$clog2(NUM_RECORDS)-1:0]     rd_index,
    output record_t                            rd_data,
    output logic                               rd_valid,
    output logic [$clog2(NUM_RECORDS+1)-1:0]   rec_count
);

    localparam int IW = $clog2(NUM_RECORDS);
    localparam int CW = $clog2(NUM_RECORDS + 1);

    record_t       mem [NUM_RECORDS];
    logic [IW-1:0] wr_ptr;
    logic [IW-1:0] rd_slot;

    // Index 0 is the slot just behind the write pointer
    assign rd_slot = IW'((int'(wr_ptr) + NUM_RECORDS - 1 - int'(rd_index)) % NUM_RECORDS);

    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            wr_ptr    <= '0;
            rec_count <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= rd;
            if (wr) begin
                wr_ptr <= (wr_ptr == IW'(NUM_RECORDS - 1)) ? '0 : wr_ptr + 1'b1;
                if (rec_count != CW'(NUM_RECORDS)) begin
                    rec_count <= rec_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd) begin
            rd_data <= mem[rd_slot];
        end
    end

endmodule

// ==== hw/page_sequencer.sv ====
module page_sequencer import game_pkg::*; (
    input  logic       clk,
    input  logic       sys_rst,
    input  logic       go_play,
    input  logic       go_history,
    input  logic       go_menu_play,
    input  logic       go_menu_hist,
    output logic       rst_menu,
    output logic       rst_play,
    output logic       rst_hist,
    input  logic       play_wr,
    input  logic       hist_rd,
    output logic       store_wr,
    output logic       store_rd,
    output page_t      cur_page,
    input  logic [7:0] menu_seg,
    input  logic [7:0] play_seg,
    input  logic [7:0] hist_seg,
    output logic [7:0] seg_value
);

    page_t next_page;

    // Requests count only when they come from the current page
    always_comb begin
        next_page = cur_page;
        case (cur_page)
            PAGE_MENU: begin
                if (go_play) begin
                    next_page = PAGE_PLAY;
                end else if (go_history) begin
                    next_page = PAGE_HISTORY;
                end
            end
            PAGE_PLAY: begin
                if (go_menu_play) begin
                    next_page = PAGE_MENU;
                end
            end
            PAGE_HISTORY: begin
                if (go_menu_hist) begin
                    next_page = PAGE_MENU;
                end
            end
            default: next_page = PAGE_MENU;
        endcase
    end

    // Page resets come from flops, so the pages see a clean reset edge
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            cur_page <= PAGE_MENU;
            rst_play <= 1'b1;
            rst_hist <= 1'b1;
        end else begin
            cur_page <= next_page;
            rst_play <= (next_page != PAGE_PLAY);
            rst_hist <= (next_page != PAGE_HISTORY);
        end
    end

    // Menu keeps chart and auto-play across pages
    assign rst_menu = sys_rst;

    // Record port belongs to the current page
    assign store_wr = play_wr && (cur_page == PAGE_PLAY);
    assign store_rd = hist_rd && (cur_page == PAGE_HISTORY);

    always_comb begin
        case (cur_page)
            PAGE_PLAY:    seg_value = play_seg;
            PAGE_HISTORY: seg_value = hist_seg;
            default:      seg_value = menu_seg;
        endcase
    end

endmodule

// ==== hw/page_menu.sv ====
module page_menu import game_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic [3:0] nav_press,
    input  logic [6:0] note_press,
    output logic [1:0] sel_chart,
    output logic       auto_play,
    output logic       go_play,
    output logic       go_history,
    output logic [7:0] menu_seg
);

    logic [1:0] chart_next;
    logic [1:0] chart_prev;

    assign chart_next = (sel_chart == 2'(NUM_CHARTS - 1)) ? 2'd0 : sel_chart + 2'd1;
    assign chart_prev = (sel_chart == 2'd0) ? 2'(NUM_CHARTS - 1) : sel_chart - 2'd1;

    // tick is only high here while the menu is the current page
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_chart <= 2'd0;
            auto_play <= 1'b0;
        end else if (tick) begin
            if (nav_press[BTN_UP]) begin
                sel_chart <= chart_next;
            end else if (nav_press[BTN_DOWN]) begin
                sel_chart <= chart_prev;
            end
            if (note_press[0]) begin
                auto_play <= ~auto_play;
            end
        end
    end

    assign go_play    = tick && nav_press[BTN_OK];
    assign go_history = tick && nav_press[BTN_BACK];

    // Auto-play flag in bit 4, chart number in bits 1:0
    assign menu_seg = {3'b000, auto_play, 2'b00, sel_chart};

endmodule

// ==== hw/page_play.sv ====
module page_play import game_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic [6:0] note_press,
    input  logic [1:0] sel_chart,
    input  logic       auto_play,
    input  logic [3:0] user_id,
    output logic [6:0] note_cue,
    output logic       play_wr,
    output record_t    play_wr_data,
    output logic       go_menu_play,
    output logic [7:0] play_seg
);

    localparam int NW = $clog2(CHART_LEN);
    localparam int TW = (NOTE_TICKS > 1) ? $clog2(NOTE_TICKS) : 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_NOTES,
        S_WRITE,
        S_EXIT,
        S_DONE
    } phase_t;

    phase_t         phase;
    logic [NW-1:0]  note_idx;
    logic [TW-1:0]  tick_cnt;
    logic [CHART_LEN-1:0] hit;
    logic [3:0]     score;
    logic [2:0]     cue_note;
    logic           note_hit;

    assign cue_note = CHART_TABLE[sel_chart][note_idx];

    // Each note scores at most once, and only its own key counts
    assign note_hit = tick && !hit[note_idx] && (auto_play || note_press[cue_note]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= S_IDLE;
            note_idx <= '0;
            tick_cnt <= '0;
            hit      <= '0;
            score    <= 4'd0;
        end else begin
            case (phase)
                S_IDLE: phase <= S_NOTES;
                S_NOTES: begin
                    if (note_hit) begin
                        hit[note_idx] <= 1'b1;
                        score         <= score + 4'd1;
                    end
                    if (tick) begin
                        if (tick_cnt == TW'(NOTE_TICKS - 1)) begin
                            tick_cnt <= '0;
                            if (note_idx == NW'(CHART_LEN - 1)) begin
                                phase <= S_WRITE;
                            end else begin
                                note_idx <= note_idx + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                // Record goes out one tick after the last note, exit one tick later
                S_WRITE: begin
                    if (tick) begin
                        phase <= S_EXIT;
                    end
                end
                S_EXIT: begin
                    if (tick) begin
                        phase <= S_DONE;
                    end
                end
                default: phase <= S_DONE;
            endcase
        end
    end

    assign note_cue     = (phase == S_NOTES) ? (7'b000_0001 << cue_note) : 7'b000_0000;
    assign play_wr      = (phase == S_WRITE) && tick;
    assign go_menu_play = (phase == S_EXIT) && tick;
    assign play_seg     = {4'b0000, score};

    always_comb begin
        play_wr_data          = '0;
        play_wr_data.user_id  = user_id;
        play_wr_data.chart_id = sel_chart;
        play_wr_data.score    = score;
    end

endmodule

// ==== hw/page_history.sv ====
module page_history import game_pkg::*; #(
    parameter int NUM_RECORDS = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               tick,
    input  logic [3:0]                         nav_press,
    input  logic [$clog2(NUM_RECORDS+1)-1:0]   rec_count,
    output logic                               hist_rd,
    output logic [$clog2(NUM_RECORDS)-1:0]     rd_index,
    input  record_t                            rd_data,
    input  logic                               rd_valid,
    output logic [7:0]                         hist_seg,
    output logic                               go_menu_hist
);

    localparam int IW = $clog2(NUM_RECORDS);

    logic          started;
    logic [IW-1:0] idx;
    logic          step_up;
    logic          step_down;
    record_t       shown;

    assign step_up   = tick && nav_press[BTN_UP];
    assign step_down = tick && nav_press[BTN_DOWN];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started <= 1'b0;
            idx     <= '0;
            hist_rd <= 1'b0;
            shown   <= '0;
        end else begin
            started <= 1'b1;
            // First cycle after entry fetches the newest record
            hist_rd <= !started || step_up || step_down;
            // UP goes newer, DOWN goes older, both clamped to stored records
            if (step_up && idx != '0) begin
                idx <= idx - 1'b1;
            end else if (step_down && (int'(idx) + 1 < int'(rec_count))) begin
                idx <= idx + 1'b1;
            end
            if (rd_valid) begin
                shown <= rd_data;
            end
        end
    end

    assign rd_index     = idx;
    assign hist_seg     = (rec_count == '0) ? 8'h00 : {shown.user_id, shown.score};
    assign go_menu_hist = tick && nav_press[BTN_BACK];

endmodule

// ==== hw/game_top.sv ====
module game_top import game_pkg::*; #(
    parameter int FREQ_DIV    = 1000,
    parameter int NUM_RECORDS = 8
) (
    input  logic       clk,
    input  logic       sys_rst,
    input  logic [3:0] btn_arr,
    input  logic [6:0] btn_notes,
    input  logic [3:0] sw_user_id,
    output logic [7:0] seg_value,
    output logic [6:0] note_cue,
    output logic [7:0] led
);

    localparam int IW = $clog2(NUM_RECORDS);
    localparam int CW = $clog2(NUM_RECORDS + 1);

    logic          tick;
    logic          menu_tick;
    logic [3:0]    nav_press;
    logic [6:0]    note_press;
    page_t         cur_page;
    logic          rst_menu;
    logic          rst_play;
    logic          rst_hist;
    logic          go_play;
    logic          go_history;
    logic          go_menu_play;
    logic          go_menu_hist;
    logic [1:0]    sel_chart;
    logic          auto_play;
    logic [7:0]    menu_seg;
    logic [7:0]    play_seg;
    logic [7:0]    hist_seg;
    logic          play_wr;
    record_t       play_wr_data;
    logic          hist_rd;
    logic [IW-1:0] rd_index;
    logic          store_wr;
    logic          store_rd;
    record_t       rd_data;
    logic          rd_valid;
    logic [CW-1:0] rec_count;

    prog_tick_gen #(.FREQ_DIV(FREQ_DIV)) i_tick_gen (
        .clk(clk), .sys_rst(sys_rst), .tick(tick)
    );

    key_events i_key_events (
        .clk(clk), .sys_rst(sys_rst), .tick(tick),
        .btn_arr(btn_arr), .btn_notes(btn_notes),
        .nav_press(nav_press), .note_press(note_press)
    );

    page_sequencer i_sequencer (
        .clk(clk), .sys_rst(sys_rst),
        .go_play(go_play), .go_history(go_history),
        .go_menu_play(go_menu_play), .go_menu_hist(go_menu_hist),
        .rst_menu(rst_menu), .rst_play(rst_play), .rst_hist(rst_hist),
        .play_wr(play_wr), .hist_rd(hist_rd),
        .store_wr(store_wr), .store_rd(store_rd), .cur_page(cur_page),
        .menu_seg(menu_seg), .play_seg(play_seg), .hist_seg(hist_seg),
        .seg_value(seg_value)
    );

    record_store #(.NUM_RECORDS(NUM_RECORDS)) i_store (
        .clk(clk), .sys_rst(sys_rst),
        .wr(store_wr), .wr_data(play_wr_data),
        .rd(store_rd), .rd_index(rd_index),
        .rd_data(rd_data), .rd_valid(rd_valid), .rec_count(rec_count)
    );

    // Menu is never held in reset, so it only sees ticks while it is current
    assign menu_tick = tick && (cur_page == PAGE_MENU);

    page_menu i_menu (
        .clk(clk), .rst(rst_menu), .tick(menu_tick),
        .nav_press(nav_press), .note_press(note_press),
        .sel_chart(sel_chart), .auto_play(auto_play),
        .go_play(go_play), .go_history(go_history), .menu_seg(menu_seg)
    );

    page_play i_play (
        .clk(clk), .rst(rst_play), .tick(tick), .note_press(note_press),
        .sel_chart(sel_chart), .auto_play(auto_play), .user_id(sw_user_id),
        .note_cue(note_cue), .play_wr(play_wr), .play_wr_data(play_wr_data),
        .go_menu_play(go_menu_play), .play_seg(play_seg)
    );

    page_history #(.NUM_RECORDS(NUM_RECORDS)) i_history (
        .clk(clk), .rst(rst_hist), .tick(tick), .nav_press(nav_press),
        .rec_count(rec_count), .hist_rd(hist_rd), .rd_index(rd_index),
        .rd_data(rd_data), .rd_valid(rd_valid),
        .hist_seg(hist_seg), .go_menu_hist(go_menu_hist)
    );

    assign led[0]   = (cur_page == PAGE_MENU);
    assign led[1]   = (cur_page == PAGE_HISTORY);
    assign led[2]   = (cur_page == PAGE_PLAY);
    assign led[3]   = auto_play;
    assign led[6:4] = 3'b000;
    assign led[7]   = sys_rst;

endmodule

// ==== dv/game_assert.sv ====
module game_assert import game_pkg::*; #(
    parameter bit STORE_SIDE  = 1'b0,
    parameter int NUM_RECORDS = 8,
    parameter int CW          = 4
) (
    input logic          clk,
    input logic          sys_rst,
    input page_t         cur_page,
    input logic          wr,
    input logic          rd,
    input logic          rd_valid,
    input logic [CW-1:0] rec_count
);

    timeunit 1ns;
    timeprecision 1ps;

    if (!STORE_SIDE) begin : g_seq
        a_page_legal: assert property (@(posedge clk) disable iff (sys_rst)
            cur_page inside {PAGE_MENU, PAGE_HISTORY, PAGE_PLAY})
            else $error("cur_page holds an illegal value");

        // Only the play page may append records
        a_wr_owner: assert property (@(posedge clk) disable iff (sys_rst)
            wr |-> cur_page == PAGE_PLAY)
            else $error("record write outside the play page");
    end else begin : g_store
        a_count_max: assert property (@(posedge clk) disable iff (sys_rst)
            rec_count <= CW'(NUM_RECORDS))
            else $error("rec_count above the memory depth");

        a_rd_valid: assert property (@(posedge clk) disable iff (sys_rst)
            rd |=> rd_valid)
            else $error("rd_valid missing one cycle after a read");

        a_rd_quiet: assert property (@(posedge clk) disable iff (sys_rst)
            !rd |=> !rd_valid)
            else $error("rd_valid without a read");
    end

endmodule

bind page_sequencer game_assert #(.STORE_SIDE(1'b0)) i_seq_assert (
    .clk(clk), .sys_rst(sys_rst), .cur_page(cur_page),
    .wr(play_wr), .rd(store_rd), .rd_valid(1'b0), .rec_count('0)
);

bind record_store game_assert #(
    .STORE_SIDE(1'b1), .NUM_RECORDS(NUM_RECORDS), .CW(CW)
) i_store_assert (
    .clk(clk), .sys_rst(sys_rst), .cur_page(PAGE_MENU),
    .wr(wr), .rd(rd), .rd_valid(rd_valid), .rec_count(rec_count)
);

// ==== dv/game_tb.sv ====
module game_tb import game_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FREQ_DIV    = 4;
    localparam int NUM_RECORDS = 8;
    localparam int HOLD_CYCLES = 3 * FREQ_DIV;
    localparam int WAIT_LIMIT  = 200;
    localparam int NUM_ROWS    = 4;
    localparam int EXTRA_PLAYS = 6;

    localparam logic [3:0] KEY_UP   = 4'(1 << BTN_UP);
    localparam logic [3:0] KEY_DOWN = 4'(1 << BTN_DOWN);
    localparam logic [3:0] KEY_OK   = 4'(1 << BTN_OK);
    localparam logic [3:0] KEY_BACK = 4'(1 << BTN_BACK);
    localparam logic [2:0] LED_MENU = 3'b001;
    localparam logic [2:0] LED_HIST = 3'b010;
    localparam logic [2:0] LED_PLAY = 3'b100;

    typedef struct packed {
        logic [1:0] chart;
        logic       auto_on;
        logic [7:0] mask;
        logic [3:0] user;
        logic [3:0] score;
        logic [7:0] hist;
    } row_t;

    // chart, auto, hit mask (bit n = note n), user, score, history display
    localparam row_t ROWS [NUM_ROWS] = '{
        '{2'd1, 1'b0, 8'b1010_0101, 4'd3,  4'd4, 8'h34},
        '{2'd2, 1'b1, 8'b0000_0000, 4'd5,  4'd8, 8'h58},
        '{2'd0, 1'b0, 8'b1111_1111, 4'd9,  4'd8, 8'h98},
        '{2'd3, 1'b0, 8'b0000_0000, 4'd12, 4'd0, 8'hc0}
    };

    logic       clk;
    logic       sys_rst;
    logic [3:0] btn_arr;
    logic [6:0] btn_notes;
    logic [3:0] sw_user_id;
    logic [7:0] seg_value;
    logic [6:0] note_cue;
    logic [7:0] led;

    int         errors;
    int         checks;
    int         tests;
    int         menu_chart;
    logic       stalled;
    logic [7:0] hist_q [$];

    game_top #(.FREQ_DIV(FREQ_DIV), .NUM_RECORDS(NUM_RECORDS)) i_dut (
        .clk(clk), .sys_rst(sys_rst), .btn_arr(btn_arr), .btn_notes(btn_notes),
        .sw_user_id(sw_user_id), .seg_value(seg_value), .note_cue(note_cue), .led(led)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Inputs change and outputs are sampled 2 ns after the rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s, expected %0h, got %0h", $time, what, expected, got);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
        end
    endtask

    task automatic press_nav(input logic [3:0] keys);
        btn_arr = keys;
        step(HOLD_CYCLES);
        btn_arr = '0;
        step(HOLD_CYCLES);
    endtask

    task automatic press_note(input logic [6:0] keys);
        btn_notes = keys;
        step(HOLD_CYCLES);
        btn_notes = '0;
        step(HOLD_CYCLES);
    endtask

    // Short pulse so that two of them fit inside one note
    task automatic note_pulse(input logic [6:0] keys);
        btn_notes = keys;
        step(FREQ_DIV);
        btn_notes = '0;
        step(FREQ_DIV - 1);
    endtask

    task automatic wait_page(input logic [2:0] want, input string name);
        int n;
        n = 0;
        if (!stalled) begin
            while (led[2:0] != want && n < WAIT_LIMIT) begin
                step(1);
                n++;
            end
            if (led[2:0] != want) begin
                stalled = 1'b1;
                errors++;
                $display("ERROR: the %s page never became current (%0t)", name, $time);
            end
        end
    endtask

    task automatic wait_cue(input logic [6:0] prev, output logic [6:0] cue);
        int n;
        n = 0;
        if (!stalled) begin
            while (note_cue == prev && n < WAIT_LIMIT) begin
                step(1);
                n++;
            end
            if (note_cue == prev) begin
                stalled = 1'b1;
                errors++;
                $display("ERROR: the note cue stopped changing (%0t)", $time);
            end
        end
        cue = note_cue;
    endtask

    task automatic set_menu(input logic [1:0] chart, input logic auto_on);
        int n;
        n = 0;
        while (seg_value[1:0] != chart && n < NUM_CHARTS) begin
            press_nav(KEY_UP);
            menu_chart = (menu_chart + 1) % NUM_CHARTS;
            n++;
        end
        if (led[3] !== auto_on) begin
            press_note(7'b000_0001);
        end
        check_eq(32'(seg_value), 32'({3'b000, auto_on, 2'b00, chart}), "menu before play");
    endtask

    task automatic play_once(input logic [1:0] chart, input logic auto_on,
                             input logic [7:0] mask, input logic [3:0] user,
                             input logic [3:0] score, input logic [7:0] hist);
        logic [6:0] cue;
        logic [6:0] wrong;
        logic [6:0] key;
        int n;
        sw_user_id = user;
        set_menu(chart, auto_on);
        btn_arr = KEY_OK;
        wait_cue(7'd0, cue);
        btn_arr = '0;
        check_eq(32'(led[2:0]), 32'(LED_PLAY), "play page led");
        for (n = 0; n < CHART_LEN; n++) begin
            if (n > 0) begin
                wait_cue(cue, cue);
            end
            check_eq(32'(cue), 32'(7'b000_0001 << CHART_TABLE[chart][n[2:0]]), "note cue");
            wrong = {cue[5:0], cue[6]};
            key = mask[n[2:0]] ? cue : wrong;
            // A hit is pressed twice, a miss gets two wrong keys
            note_pulse(key);
            note_pulse(key);
        end
        wait_cue(cue, cue);
        check_eq(32'(cue), 32'd0, "cue after last note");
        check_eq(32'(seg_value), 32'(score), "final score");
        wait_page(LED_MENU, "menu");
        check_eq(32'(seg_value[1:0]), 32'(chart), "chart kept after play");
        press_nav(KEY_BACK);
        wait_page(LED_HIST, "history");
        check_eq(32'(seg_value), 32'(hist), "newest history entry");
        press_nav(KEY_BACK);
        wait_page(LED_MENU, "menu");
        hist_q.push_front(hist);
    endtask

    initial begin
        int         mark;
        int         p;
        logic [5:0] up_steps;
        logic [3:0] user;
        logic [7:0] mask;
        logic [3:0] score;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        menu_chart = 0;
        stalled    = 1'b0;
        up_steps   = 6'b100011;
        sys_rst    = 1'b1;
        btn_arr    = '0;
        btn_notes  = '0;
        sw_user_id = '0;
        void'($urandom(33));
        repeat (3) @(posedge clk);
        #2;

        // Reset shows on led[7] next to the menu page
        mark = errors;
        check_eq(32'(led), 32'h81, "led during reset");
        sys_rst = 1'b0;
        step(2);

        check_eq(32'(led), 32'h01, "led after reset");
        check_eq(32'(seg_value), 32'd0, "display after reset");
        check_eq(32'(note_cue), 32'd0, "cue after reset");
        report_test("reset state", mark);

        // UP UP DOWN DOWN DOWN UP walks 0 1 2 1 0 3 0
        mark = errors;
        for (p = 0; p < 6; p++) begin
            if (up_steps[p[2:0]]) begin
                press_nav(KEY_UP);
                menu_chart = (menu_chart + 1) % NUM_CHARTS;
            end else begin
                press_nav(KEY_DOWN);
                menu_chart = (menu_chart + NUM_CHARTS - 1) % NUM_CHARTS;
            end
            check_eq(32'(seg_value[1:0]), 32'(menu_chart), "menu chart step");
        end
        press_note(7'b000_0001);
        check_eq(32'(led[3]), 32'd1, "auto led on");
        check_eq(32'(seg_value[4]), 32'd1, "auto display on");
        press_note(7'b000_0001);
        check_eq(32'(led[3]), 32'd0, "auto led off");
        check_eq(32'(seg_value[4]), 32'd0, "auto display off");
        report_test("menu navigation", mark);

        for (p = 0; p < NUM_ROWS; p++) begin
            mark = errors;
            play_once(ROWS[p[1:0]].chart, ROWS[p[1:0]].auto_on, ROWS[p[1:0]].mask,
                      ROWS[p[1:0]].user, ROWS[p[1:0]].score, ROWS[p[1:0]].hist);
            report_test($sformatf("table play %0d", p), mark);
        end

        for (p = 0; p < EXTRA_PLAYS; p++) begin
            mark = errors;
            user = 4'($urandom);
            mask = 8'($urandom);
            score = 4'($countones(mask));
            play_once(2'(p % NUM_CHARTS), 1'b0, mask, user, score, {user, score});
            report_test($sformatf("random play %0d", p), mark);
        end

        // Ten plays in an eight-deep ring, so index 7 is the third play
        mark = errors;
        press_nav(KEY_BACK);
        wait_page(LED_HIST, "history");
        check_eq(32'(seg_value), 32'(hist_q[0]), "history index 0");
        for (p = 1; p < NUM_RECORDS; p++) begin
            press_nav(KEY_DOWN);
            check_eq(32'(seg_value), 32'(hist_q[p]), $sformatf("history index %0d", p));
        end
        press_nav(KEY_DOWN);
        check_eq(32'(seg_value), 32'(hist_q[NUM_RECORDS - 1]), "history stops at oldest");
        press_nav(KEY_UP);
        check_eq(32'(seg_value), 32'(hist_q[NUM_RECORDS - 2]), "history step newer");
        report_test("history browse", mark);

        // Menu page only, auto-play off after the last manual play
        mark = errors;
        press_nav(KEY_BACK);
        wait_page(LED_MENU, "menu");
        check_eq(32'(led), 32'h01, "led after history");
        check_eq(32'(seg_value[1:0]), 32'(menu_chart), "chart kept after history");
        report_test("history exit", mark);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/game_pkg.sv
hw/prog_tick_gen.sv
hw/key_events.sv
hw/record_store.sv
hw/page_sequencer.sv
hw/page_menu.sv
hw/page_play.sv
hw/page_history.sv
hw/game_top.sv
dv/game_assert.sv
dv/game_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= game_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
